//--- vlog.f
rtl/muldiv_pkg.sv
rtl/mul_unit.sv
rtl/div_unit.sv
rtl/muldiv_unit.sv
test/muldiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the muldiv testbench with Verilator, fails on TEST FAILED in the log
set -o pipefail

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module muldiv_tb \
  -f vlog.f -Mdir obj_dir -o muldiv_sim &&
  ./obj_dir/muldiv_sim 2>&1 | tee sim.log &&
  ! grep -q "TEST FAILED" sim.log &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

exit 0

//--- test/muldiv_tb.sv
`timescale 1ns/100ps

module muldiv_tb;

  import muldiv_pkg::*;

  localparam int n_ops    = 100 + 16 + 6 + 40;  // operations issued over all tests
  localparam int max_wait = 100;                // cycles before a lost done is reported

  logic    clk;
  logic    rst;
  logic    start;
  funct3_t funct3;
  word_t   a;
  word_t   b;
  logic    done;
  logic    busy;
  word_t   res;

  logic [31:0] seed;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;

  muldiv_unit muldiv_unit_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .funct3 (funct3),
    .a      (a),
    .b      (b),
    .done   (done),
    .busy   (busy),
    .res    (res)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // expected result straight from the RISC-V M rules
  function automatic word_t model_op(input funct3_t f, input word_t x, input word_t y);
    logic [63:0]        p_ss;
    logic [63:0]        p_su;
    logic [63:0]        p_uu;
    logic signed [31:0] sx;
    logic signed [31:0] sy;
    word_t              r;
    sx   = x;
    sy   = y;
    p_ss = {{32{x[31]}}, x} * {{32{y[31]}}, y};
    p_su = {{32{x[31]}}, x} * {32'b0, y};
    p_uu = {32'b0, x} * {32'b0, y};
    r    = '0;
    case (f)
      f3_mul:    r = p_uu[31:0];
      f3_mulh:   r = p_ss[63:32];
      f3_mulhsu: r = p_su[63:32];
      f3_mulhu:  r = p_uu[63:32];
      f3_div: begin
        if (y == '0) r = '1;
        else if (x == 32'h8000_0000 && y == '1) r = x;  // overflow
        else r = sx / sy;
      end
      f3_divu: begin
        if (y == '0) r = '1;
        else r = x / y;
      end
      f3_rem: begin
        if (y == '0) r = x;
        else if (x == 32'h8000_0000 && y == '1) r = '0;
        else r = sx % sy;  // sign follows the dividend
      end
      default: begin
        if (y == '0) r = x;
        else r = x % y;
      end
    endcase
    return r;
  endfunction

  task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("[PASS] %s", name);
    end else begin
      fail_cnt++;
      $display("[FAIL] %s, %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // entered and left 10 ns after a rising edge
  task automatic run_op(input funct3_t f, input word_t op_a, input word_t op_b,
                        input word_t exp);
    string tag;
    int    cycles;
    int    exp_cycles;
    tag        = $sformatf("res f3=%0d a=%h b=%h", f, op_a, op_b);
    exp_cycles = f[2] ? 33 : 2;
    start      = 1'b1;
    funct3     = f;
    a          = op_a;
    b          = op_b;
    @(posedge clk);
    #10;
    start  = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      check("busy", word_t'(busy), 32'h1);
    end while (!done && cycles < max_wait);
    if (!done) begin
      $display("no done pulse within %0d cycles for funct3 %0d", max_wait, f);
      err_cnt++;
    end else begin
      check("done latency", cycles, exp_cycles);
      check(tag, res, exp);
    end
    @(posedge clk);
    #10;
    check("done", word_t'(done), 32'h0);  // one-cycle pulse
    check("busy", word_t'(busy), 32'h0);
    check("res hold", res, exp);
  endtask

  task automatic reset_values();
    int errs;
    errs = err_cnt;
    check("done", word_t'(done), 32'h0);
    check("busy", word_t'(busy), 32'h0);
    check("res", res, 32'h0);
    report_test("reset values", errs);
  endtask

  task automatic corner_multiplies();
    word_t vals [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    int    errs;
    errs = err_cnt;
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          run_op(funct3_t'(f), vals[i], vals[j],
                 model_op(funct3_t'(f), vals[i], vals[j]));
        end
      end
    end
    report_test("multiply corner values", errs);
  endtask

  task automatic mixed_sign_divides();
    word_t na [4] = '{32'd1000003, -32'd1000003, 32'd1000003, -32'd1000003};
    word_t nb [4] = '{32'd37, 32'd37, -32'd37, -32'd37};
    int    errs;
    errs = err_cnt;
    for (int f = 4; f < 8; f++) begin
      for (int i = 0; i < 4; i++) begin
        run_op(funct3_t'(f), na[i], nb[i], model_op(funct3_t'(f), na[i], nb[i]));
      end
    end
    report_test("divide mixed signs", errs);
  endtask

  task automatic zero_overflow_divides();
    int errs;
    errs = err_cnt;
    run_op(f3_div, 32'hdead_beef, 32'h0, 32'hffff_ffff);
    run_op(f3_divu, 32'hdead_beef, 32'h0, 32'hffff_ffff);
    run_op(f3_rem, 32'hdead_beef, 32'h0, 32'hdead_beef);
    run_op(f3_remu, 32'hdead_beef, 32'h0, 32'hdead_beef);
    run_op(f3_div, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    run_op(f3_rem, 32'h8000_0000, 32'hffff_ffff, 32'h0);
    report_test("divide by zero and overflow", errs);
  endtask

  task automatic random_operations();
    logic [31:0] r;
    funct3_t     f;
    word_t       ra;
    word_t       rb;
    int          errs;
    errs = err_cnt;
    for (int n = 0; n < 40; n++) begin
      r  = next_rand();
      f  = r[30:28];  // upper bits have the longer period
      ra = next_rand();
      rb = next_rand();
      run_op(f, ra, rb, model_op(f, ra, rb));
    end
    report_test("random operations", errs);
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    start    = 1'b0;
    funct3   = f3_mul;
    a        = '0;
    b        = '0;
    seed     = 32'h6930_2a38;
    err_cnt  = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;
    reset_values();
    corner_multiplies();
    mixed_sign_divides();
    zero_overflow_divides();
    random_operations();
    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // budget of 200 cycles per operation
  initial begin
    repeat (n_ops * 200 + 100) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not complete", n_ops * 200 + 100);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- rtl/muldiv_unit.sv
`timescale 1ns/100ps

module muldiv_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  muldiv_pkg::funct3_t funct3,
  input  muldiv_pkg::word_t   a,
  input  muldiv_pkg::word_t   b,
  output logic                done,
  output logic                busy,
  output muldiv_pkg::word_t   res
);

  import muldiv_pkg::*;

  logic  accept;
  logic  mul_start;
  logic  div_start;
  logic  mul_fin;
  logic  div_fin;
  word_t mul_res;
  word_t div_res;
  logic  div_sel;  // last started unit
  logic  busy_q;

  assign accept    = start & ~busy_q;  // starts while busy are dropped
  assign mul_start = accept & ~funct3[2];
  assign div_start = accept & funct3[2];

  mul_unit mul_unit_i (
    .clk   (clk),
    .rst   (rst),
    .start (mul_start),
    .op    (funct3[1:0]),
    .a     (a),
    .b     (b),
    .done  (mul_fin),
    .res   (mul_res)
  );

  div_unit div_unit_i (
    .clk   (clk),
    .rst   (rst),
    .start (div_start),
    .op    (funct3[1:0]),
    .a     (a),
    .b     (b),
    .done  (div_fin),
    .res   (div_res)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q  <= 1'b0;
      div_sel <= 1'b0;
    end else begin
      if (accept) begin
        busy_q  <= 1'b1;
        div_sel <= funct3[2];
      end else if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign done = mul_fin | div_fin;
  assign busy = busy_q;
  assign res  = div_sel ? div_res : mul_res;

  assert property (@(posedge clk) disable iff (rst) start |-> !busy)
    else $error("start while busy");

  assert property (@(posedge clk) disable iff (rst) !(mul_fin && div_fin))
    else $error("both units finished together");

  // end to end latency through either unit
  assert property (@(posedge clk) disable iff (rst) mul_start |-> ##2 done)
    else $error("multiply did not finish in 2 cycles");

  assert property (@(posedge clk) disable iff (rst) div_start |-> ##33 done)
    else $error("divide did not finish in 33 cycles");

endmodule

//--- rtl/div_unit.sv
`timescale 1ns/100ps

module div_unit (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [1:0]        op,
  input  muldiv_pkg::word_t a,
  input  muldiv_pkg::word_t b,
  output logic              done,
  output muldiv_pkg::word_t res
);

  import muldiv_pkg::*;

  div_state_t    state;
  bit_idx_t      index;
  word_t         numerator;
  word_t         divisor;
  word_t         quotient;
  word_t         remainder;
  logic          invert;
  logic          rem_sel;
  logic          is_signed;
  logic          inv_next;
  word_t         abs_a;
  word_t         abs_b;
  logic [xlen:0] rem_shift;  // one bit wider, shifted value can exceed 32 bits
  logic [xlen:0] rem_diff;
  logic          take;
  word_t         q_out;
  word_t         r_out;

  assign is_signed = (op == f3_div[1:0]) || (op == f3_rem[1:0]);

  assign abs_a = (is_signed && a[xlen-1]) ? -a : a;
  assign abs_b = (is_signed && b[xlen-1]) ? -b : b;

  // quotient sign only flips for a nonzero divisor, remainder takes a's sign
  assign inv_next = ((op == f3_div[1:0]) && (a[xlen-1] != b[xlen-1]) && (|b)) ||
                    ((op == f3_rem[1:0]) && a[xlen-1]);

  assign rem_shift = {remainder, numerator[index]};
  assign rem_diff  = rem_shift - {1'b0, divisor};
  assign take      = ~rem_diff[xlen];  // no borrow, divisor fits

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= div_idle;
      index   <= '0;
      invert  <= 1'b0;
      rem_sel <= 1'b0;
    end else begin
      case (state)
        div_idle: begin
          if (start) begin
            index   <= bit_idx_t'(xlen - 1);
            invert  <= inv_next;
            rem_sel <= op[1];  // REM and REMU
            state   <= div_calc;
          end
        end
        div_calc: begin
          index <= index - 1'b1;
          if (index == '0) begin
            state <= div_done;
          end
        end
        default: begin
          state <= div_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == div_idle && start) begin
      numerator <= abs_a;
      divisor   <= abs_b;
      quotient  <= '0;
      remainder <= '0;
    end else if (state == div_calc) begin
      remainder       <= take ? rem_diff[xlen-1:0] : rem_shift[xlen-1:0];
      quotient[index] <= take;
    end
  end

  assign q_out = invert ? -quotient : quotient;
  assign r_out = invert ? -remainder : remainder;

  assign done = (state == div_done);
  assign res  = rem_sel ? r_out : q_out;

  // the top level must hold off until the previous divide has retired
  assert property (@(posedge clk) disable iff (rst) start |-> state == div_idle)
    else $error("div_unit started while not idle");

endmodule

//--- rtl/mul_unit.sv
`timescale 1ns/100ps

module mul_unit (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [1:0]        op,
  input  muldiv_pkg::word_t a,
  input  muldiv_pkg::word_t b,
  output logic              done,
  output muldiv_pkg::word_t res
);

  import muldiv_pkg::*;

  logic                     a_sgn;
  logic                     b_sgn;
  logic                     hi_sel;
  logic signed [xlen:0]     a_ext;     // stage 1 operands
  logic signed [xlen:0]     b_ext;
  logic                     hi_s1;
  logic                     vld_s1;
  logic signed [2*xlen+1:0] prod_full; // 33x33 signed product
  dword_t                   prod;      // stage 2
  logic                     hi_s2;
  logic                     done_q;

  // MULHU is the only form with an unsigned a; b is signed for MUL and MULH
  assign a_sgn  = (op != f3_mulhu[1:0]);
  assign b_sgn  = (op == f3_mul[1:0]) || (op == f3_mulh[1:0]);
  assign hi_sel = (op != f3_mul[1:0]);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vld_s1 <= 1'b0;
    end else begin
      vld_s1 <= start;
    end
  end

  // operands only move on start
  always_ff @(posedge clk) begin
    if (start) begin
      a_ext <= {a_sgn & a[xlen-1], a};  // sign or zero extend
      b_ext <= {b_sgn & b[xlen-1], b};
      hi_s1 <= hi_sel;
    end
  end

  assign prod_full = a_ext * b_ext;

  // product kept until the next operation so res stays put
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done_q <= 1'b0;
      hi_s2  <= 1'b0;
      prod   <= '0;
    end else begin
      done_q <= vld_s1;
      if (vld_s1) begin
        prod  <= prod_full[2*xlen-1:0];
        hi_s2 <= hi_s1;
      end
    end
  end

  assign done = done_q;
  assign res  = hi_s2 ? prod[2*xlen-1:xlen] : prod[xlen-1:0];

endmodule

//--- rtl/muldiv_pkg.sv
package muldiv_pkg;

  // datapath width, fixed by the ISA
  localparam int xlen = 32;

  typedef logic [xlen-1:0]         word_t;   // operand / result
  typedef logic [2*xlen-1:0]       dword_t;  // full product
  typedef logic [2:0]              funct3_t; // M-extension op code
  typedef logic [$clog2(xlen)-1:0] bit_idx_t;

  // funct3 codes of the M extension; bit 2 picks the divider
  localparam funct3_t f3_mul    = 3'd0;
  localparam funct3_t f3_mulh   = 3'd1;
  localparam funct3_t f3_mulhsu = 3'd2;
  localparam funct3_t f3_mulhu  = 3'd3;
  localparam funct3_t f3_div    = 3'd4;
  localparam funct3_t f3_divu   = 3'd5;
  localparam funct3_t f3_rem    = 3'd6;
  localparam funct3_t f3_remu   = 3'd7;

  // restoring divider sequencing
  typedef enum logic [1:0] {
    div_idle,  // waiting for start
    div_calc,  // one quotient bit per clock
    div_done   // result valid, done high
  } div_state_t;

endpackage
